// File: src/i2s_rx_defs.svh
`ifndef I2S_RX_DEFS_SVH
`define I2S_RX_DEFS_SVH

// ------------------------------
// Data path widths
// ------------------------------

// One I2S sample per channel
`define I2S_WORD_W 16

// Wishbone word address and data bus
`define WB_ADR_W 4
`define WB_DAT_W 32

// ------------------------------
// Sample FIFO and watchdog
// ------------------------------

// 256 entries, level counter needs one more bit
`define FIFO_AW 8

// Bus clocks with no bit clock edge before the link counts as dead
`define CLK_STOP_CYCLES 64

// Returned for any unmapped register
`define DEF_REG_VALUE 32'hDADDEFAC

`endif

// File: src/i2s_rx_pkg.sv
`include "i2s_rx_defs.svh"

package i2s_rx_pkg;

	// DMA engine states, DMA_DONE only lasts one cycle
	typedef enum logic [2:0] {
		DMA_IDLE = 3'd0,
		DMA_WAIT = 3'd1,
		DMA_REQ  = 3'd2,
		DMA_XFER = 3'd3,
		DMA_DONE = 3'd4
	} dma_state_e;

	// Register map, word addresses
	typedef enum logic [`WB_ADR_W-1:0] {
		REG_I2S_EN    = 4'd0,
		REG_INTR_STS  = 4'd2,
		REG_INTR_EN   = 4'd3,
		REG_FIFO_STS  = 4'd4,
		REG_FIFO_DATA = 4'd5,
		REG_FIFO_RST  = 4'd7,
		REG_DMA_EN    = 4'd8,
		REG_DMA_STS   = 4'd9,
		REG_DMA_CNT   = 4'd10
	} reg_addr_e;

endpackage

// File: src/i2s_deserializer.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module i2s_deserializer (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  logic                   en_i,
	input  logic                   i2s_sclk_i,
	input  logic                   i2s_ws_i,
	input  logic                   i2s_din_i,
	output logic [`I2S_WORD_W-1:0] data_o,
	output logic                   push_o,
	output logic                   clk_stopped_o
);

	localparam int STOP_W = $clog2(`CLK_STOP_CYCLES) + 1;

	// Third sclk stage only feeds the edge detect
	logic [2:0]             sclk_q;
	logic [1:0]             ws_q;
	logic [1:0]             din_q;
	logic                   sclk_rise;
	logic                   ws_prev;
	logic                   ws_change;
	logic [`I2S_WORD_W-1:0] shift_r;
	logic [STOP_W-1:0]      stop_cnt;

	// ------------------------------
	// Pin synchronizers
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			sclk_q <= '0;
			ws_q   <= '0;
			din_q  <= '0;
		end else begin
			sclk_q <= {sclk_q[1:0], i2s_sclk_i};
			ws_q   <= {ws_q[0], i2s_ws_i};
			din_q  <= {din_q[0], i2s_din_i};
		end
	end

	// ws and din are aligned with sclk_q[1]
	assign sclk_rise = sclk_q[1] & ~sclk_q[2];
	assign ws_change = ws_q[1] != ws_prev;

	// ------------------------------
	// Shift in, MSB first
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (sclk_rise) begin
			shift_r <= {shift_r[`I2S_WORD_W-2:0], din_q[1]};
			// One-bit delay, this bit is the LSB of the closing word
			if (ws_change && !ws_prev)
				data_o <= {shift_r[`I2S_WORD_W-2:0], din_q[1]};
		end
	end

	// Left word done when WS leaves low
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			ws_prev <= 1'b0;
			push_o  <= 1'b0;
		end else begin
			push_o <= sclk_rise && ws_change && !ws_prev && en_i;
			if (sclk_rise)
				ws_prev <= ws_q[1];
		end
	end

	// ------------------------------
	// Bit clock watchdog
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || !en_i || sclk_rise) begin
			stop_cnt      <= '0;
			clk_stopped_o <= 1'b0;
		end else if (stop_cnt == STOP_W'(`CLK_STOP_CYCLES - 1)) begin
			clk_stopped_o <= 1'b1;
		end else begin
			stop_cnt <= stop_cnt + 1'b1;
		end
	end

endmodule

// File: src/sample_fifo.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module sample_fifo (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  logic                   flush_i,
	input  logic                   push_i,
	input  logic                   pop_i,
	input  logic [`I2S_WORD_W-1:0] data_i,
	output logic [`I2S_WORD_W-1:0] data_o,
	output logic [`FIFO_AW:0]      level_o,
	output logic                   empty_o,
	output logic                   full_o
);

	localparam int DEPTH = 1 << `FIFO_AW;

	logic [`I2S_WORD_W-1:0] mem [0:DEPTH-1];
	logic [`FIFO_AW-1:0]    wr_ptr;
	logic [`FIFO_AW-1:0]    rd_ptr;
	logic                   do_push;
	logic                   do_pop;

	// Overflow drops the sample, underflow is ignored
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign empty_o = level_o == '0;
	assign full_o  = level_o == (`FIFO_AW+1)'(DEPTH);

	// Head word shown without a read latency
	assign data_o = mem[rd_ptr];

	always_ff @(posedge wbs_clk_i) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	// ------------------------------
	// Pointers and level
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || flush_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the level alone
			if (do_push && !do_pop)
				level_o <= level_o + 1'b1;
			else if (do_pop && !do_push)
				level_o <= level_o - 1'b1;
		end
	end

endmodule

// File: src/dma_req_fsm.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module dma_req_fsm (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  logic                   start_i,
	input  logic                   pop_i,
	input  logic                   dma_active_i,
	input  logic [`FIFO_AW:0]      dma_cnt_i,
	input  logic [`FIFO_AW:0]      fifo_level_i,
	output logic                   dma_req_o,
	output logic                   done_o,
	output logic                   busy_o,
	output i2s_rx_pkg::dma_state_e state_o,
	output logic [`FIFO_AW:0]      remain_o
);

	import i2s_rx_pkg::*;

	// ------------------------------
	// State and remaining count
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			state_o  <= DMA_IDLE;
			remain_o <= '0;
		end else begin
			case (state_o)
				DMA_IDLE: if (start_i) begin
					state_o  <= DMA_WAIT;
					remain_o <= dma_cnt_i;
				end
				// Zero count finishes at once
				DMA_WAIT: if (remain_o == '0)
					state_o <= DMA_DONE;
				else if (fifo_level_i >= remain_o)
					state_o <= DMA_REQ;
				// Held here for as long as the DMA stays inactive
				DMA_REQ: if (dma_active_i)
					state_o <= DMA_XFER;
				DMA_XFER: if (pop_i) begin
					remain_o <= remain_o - 1'b1;
					if (remain_o == (`FIFO_AW+1)'(1))
						state_o <= DMA_DONE;
				end
				default: state_o <= DMA_IDLE;
			endcase
		end
	end

	// Decoded outputs
	assign dma_req_o = state_o == DMA_REQ;
	assign done_o    = state_o == DMA_DONE;
	assign busy_o    = state_o != DMA_IDLE;

endmodule

// File: src/wb_reg_block.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module wb_reg_block (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  logic                   wbs_cyc_i,
	input  logic                   wbs_stb_i,
	input  logic                   wbs_we_i,
	input  logic [`WB_ADR_W-1:0]   wbs_adr_i,
	input  logic [`WB_DAT_W-1:0]   wbs_dat_i,
	output logic [`WB_DAT_W-1:0]   wbs_dat_o,
	output logic                   wbs_ack_o,
	input  logic [`I2S_WORD_W-1:0] fifo_data_i,
	input  logic [`FIFO_AW:0]      fifo_level_i,
	input  logic                   fifo_empty_i,
	input  logic                   fifo_full_i,
	output logic                   fifo_pop_o,
	output logic                   fifo_flush_o,
	input  logic                   dma_done_i,
	input  logic                   dma_busy_i,
	input  i2s_rx_pkg::dma_state_e dma_state_i,
	input  logic [`FIFO_AW:0]      dma_remain_i,
	output logic                   dma_start_o,
	output logic [`FIFO_AW:0]      dma_cnt_o,
	input  logic                   clk_stopped_i,
	output logic                   i2s_en_o,
	output logic                   rx_intr_o,
	output logic                   dma_intr_o,
	output logic                   dis_intr_o
);

	import i2s_rx_pkg::*;

	logic                 access;
	logic                 wr;
	reg_addr_e            addr;
	logic [`WB_DAT_W-1:0] rd_data;
	logic [2:0]           intr_sts;
	logic [2:0]           intr_en;
	logic                 dma_done_sts;
	logic                 clk_stop_sts;
	logic                 clk_stopped_q;

	// New cycle seen while ack is low
	assign access = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
	assign wr     = access && wbs_we_i;
	assign addr   = reg_addr_e'(wbs_adr_i);

	// Bit 0 follows the FIFO, the rest are sticky
	assign intr_sts = {clk_stop_sts, dma_done_sts, !fifo_empty_i};

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb begin
		rd_data = '0;
		case (addr)
			REG_I2S_EN:   rd_data[0] = i2s_en_o;
			REG_INTR_STS: rd_data[2:0] = intr_sts;
			REG_INTR_EN:  rd_data[2:0] = intr_en;
			REG_FIFO_STS: begin
				rd_data[`FIFO_AW:0] = fifo_level_i;
				rd_data[16]         = fifo_empty_i;
				rd_data[17]         = fifo_full_i;
			end
			// Empty FIFO reads as zero
			REG_FIFO_DATA: if (!fifo_empty_i)
				rd_data[`I2S_WORD_W-1:0] = fifo_data_i;
			REG_FIFO_RST: rd_data = '0;
			REG_DMA_EN:   rd_data[0] = dma_busy_i;
			// DMA_DONE shows as code 0 with busy still set
			REG_DMA_STS: begin
				rd_data[1:0]              = dma_state_i[1:0];
				rd_data[2]                = dma_busy_i;
				rd_data[16 +: `FIFO_AW+1] = dma_remain_i;
			end
			REG_DMA_CNT: rd_data[`FIFO_AW:0] = dma_cnt_o;
			default:     rd_data = `DEF_REG_VALUE;
		endcase
	end

	always_ff @(posedge wbs_clk_i) begin
		if (access)
			wbs_dat_o <= rd_data;
	end

	// ------------------------------
	// Ack, strobes and registers
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			wbs_ack_o    <= 1'b0;
			fifo_pop_o   <= 1'b0;
			fifo_flush_o <= 1'b0;
			dma_start_o  <= 1'b0;
			i2s_en_o     <= 1'b0;
			intr_en      <= '0;
			dma_cnt_o    <= '0;
		end else begin
			wbs_ack_o <= access;
			// Strobes line up with the ack cycle
			fifo_pop_o   <= access && !wbs_we_i && addr == REG_FIFO_DATA && !fifo_empty_i;
			fifo_flush_o <= wr && addr == REG_FIFO_RST && wbs_dat_i[0];
			dma_start_o  <= wr && addr == REG_DMA_EN && wbs_dat_i[0];
			if (wr && addr == REG_I2S_EN)
				i2s_en_o <= wbs_dat_i[0];
			if (wr && addr == REG_INTR_EN)
				intr_en <= wbs_dat_i[2:0];
			if (wr && addr == REG_DMA_CNT)
				dma_cnt_o <= wbs_dat_i[`FIFO_AW:0];
		end
	end

	// Sticky status, a new event beats a clear
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			dma_done_sts  <= 1'b0;
			clk_stop_sts  <= 1'b0;
			clk_stopped_q <= 1'b0;
		end else begin
			clk_stopped_q <= clk_stopped_i;
			if (dma_done_i)
				dma_done_sts <= 1'b1;
			else if (wr && addr == REG_INTR_STS && wbs_dat_i[1])
				dma_done_sts <= 1'b0;
			if (clk_stopped_i && !clk_stopped_q)
				clk_stop_sts <= 1'b1;
			else if (wr && addr == REG_INTR_STS && wbs_dat_i[2])
				clk_stop_sts <= 1'b0;
		end
	end

	// Interrupt pins, one cycle behind status
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			rx_intr_o  <= 1'b0;
			dma_intr_o <= 1'b0;
			dis_intr_o <= 1'b0;
		end else begin
			rx_intr_o  <= intr_sts[0] & intr_en[0];
			dma_intr_o <= intr_sts[1] & intr_en[1];
			dis_intr_o <= intr_sts[2] & intr_en[2];
		end
	end

endmodule

// File: src/i2s_rx_dma_top.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module i2s_rx_dma_top (
	input  logic                 wbs_clk_i,
	input  logic                 rst_i,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic                 wbs_we_i,
	input  logic [`WB_ADR_W-1:0] wbs_adr_i,
	input  logic [`WB_DAT_W-1:0] wbs_dat_i,
	output logic [`WB_DAT_W-1:0] wbs_dat_o,
	output logic                 wbs_ack_o,
	input  logic                 i2s_sclk_i,
	input  logic                 i2s_ws_i,
	input  logic                 i2s_din_i,
	output logic                 dma_req_o,
	input  logic                 dma_active_i,
	output logic                 rx_intr_o,
	output logic                 dma_intr_o,
	output logic                 dis_intr_o
);

	import i2s_rx_pkg::*;

	// Deserializer to FIFO
	logic [`I2S_WORD_W-1:0] rx_data;
	logic                   rx_push;
	logic                   clk_stopped;
	logic                   i2s_en;

	// FIFO status and strobes
	logic [`I2S_WORD_W-1:0] fifo_data;
	logic [`FIFO_AW:0]      fifo_level;
	logic                   fifo_empty;
	logic                   fifo_full;
	logic                   fifo_pop;
	logic                   fifo_flush;

	// DMA engine
	logic                   dma_start;
	logic                   dma_done;
	logic                   dma_busy;
	logic [`FIFO_AW:0]      dma_cnt;
	logic [`FIFO_AW:0]      dma_remain;
	dma_state_e             dma_state;

	// ------------------------------
	// Serial front end
	// ------------------------------
	i2s_deserializer i2s_deserializer_inst (
		.wbs_clk_i     (wbs_clk_i),
		.rst_i         (rst_i),
		.en_i          (i2s_en),
		.i2s_sclk_i    (i2s_sclk_i),
		.i2s_ws_i      (i2s_ws_i),
		.i2s_din_i     (i2s_din_i),
		.data_o        (rx_data),
		.push_o        (rx_push),
		.clk_stopped_o (clk_stopped)
	);

	sample_fifo sample_fifo_inst (
		.wbs_clk_i (wbs_clk_i),
		.rst_i     (rst_i),
		.flush_i   (fifo_flush),
		.push_i    (rx_push),
		.pop_i     (fifo_pop),
		.data_i    (rx_data),
		.data_o    (fifo_data),
		.level_o   (fifo_level),
		.empty_o   (fifo_empty),
		.full_o    (fifo_full)
	);

	// Pops come only from data register reads
	dma_req_fsm dma_req_fsm_inst (
		.wbs_clk_i    (wbs_clk_i),
		.rst_i        (rst_i),
		.start_i      (dma_start),
		.pop_i        (fifo_pop),
		.dma_active_i (dma_active_i),
		.dma_cnt_i    (dma_cnt),
		.fifo_level_i (fifo_level),
		.dma_req_o    (dma_req_o),
		.done_o       (dma_done),
		.busy_o       (dma_busy),
		.state_o      (dma_state),
		.remain_o     (dma_remain)
	);

	// ------------------------------
	// Register block
	// ------------------------------
	wb_reg_block wb_reg_block_inst (
		.wbs_clk_i     (wbs_clk_i),
		.rst_i         (rst_i),
		.wbs_cyc_i     (wbs_cyc_i),
		.wbs_stb_i     (wbs_stb_i),
		.wbs_we_i      (wbs_we_i),
		.wbs_adr_i     (wbs_adr_i),
		.wbs_dat_i     (wbs_dat_i),
		.wbs_dat_o     (wbs_dat_o),
		.wbs_ack_o     (wbs_ack_o),
		.fifo_data_i   (fifo_data),
		.fifo_level_i  (fifo_level),
		.fifo_empty_i  (fifo_empty),
		.fifo_full_i   (fifo_full),
		.fifo_pop_o    (fifo_pop),
		.fifo_flush_o  (fifo_flush),
		.dma_done_i    (dma_done),
		.dma_busy_i    (dma_busy),
		.dma_state_i   (dma_state),
		.dma_remain_i  (dma_remain),
		.dma_start_o   (dma_start),
		.dma_cnt_o     (dma_cnt),
		.clk_stopped_i (clk_stopped),
		.i2s_en_o      (i2s_en),
		.rx_intr_o     (rx_intr_o),
		.dma_intr_o    (dma_intr_o),
		.dis_intr_o    (dis_intr_o)
	);

endmodule

// File: bench/i2s_rx_checker.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module i2s_rx_checker (
	input logic wbs_clk_i,
	input logic rx_intr_i,
	input logic dma_intr_i,
	input logic dis_intr_i,
	input logic dma_req_i
);

	// Running totals over the whole run
	int err_cnt   = 0;
	int check_cnt = 0;
	int test_cnt  = 0;
	// Errors in the test still open
	int test_err  = 0;

	// ------------------------------
	// Pin lookup by port name
	// ------------------------------
	function automatic logic pin_value(input string pin);
		logic v;
		if (pin == "rx_intr_o")
			v = rx_intr_i;
		else if (pin == "dma_intr_o")
			v = dma_intr_i;
		else if (pin == "dis_intr_o")
			v = dis_intr_i;
		else if (pin == "dma_req_o")
			v = dma_req_i;
		else
			v = 1'bx;
		return v;
	endfunction

	// Failure that is not a value mismatch
	task automatic report_fail(input string msg);
		err_cnt++;
		test_err++;
		$display("%s", msg);
	endtask

	// Compare one value
	task automatic check_val(input string name, input logic [`WB_DAT_W-1:0] exp,
		input logic [`WB_DAT_W-1:0] act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			test_err++;
			$display("ERR %s exp=%h act=%h", name, exp, act);
		end
	endtask

	// Pin level right now
	task automatic expect_pin(input string pin, input logic val);
		check_val(pin, 32'(val), 32'(pin_value(pin)));
	endtask

	// Bounded wait on a pin, sampled 1 ns after the edge
	task automatic wait_pin(input string pin, input logic val, input int limit);
		int n;
		n = 0;
		while (pin_value(pin) !== val && n < limit) begin
			@(posedge wbs_clk_i);
			#1;
			n++;
		end
		check_cnt++;
		if (pin_value(pin) !== val)
			report_fail($sformatf("%s did not reach %0d within %0d cycles", pin, val, limit));
	endtask

	// ------------------------------
	// Reporting
	// ------------------------------
	task automatic end_test(input string name);
		test_cnt++;
		if (test_err == 0)
			$display("test %0d %s: ok", test_cnt, name);
		else
			$display("test %0d %s: %0d errors", test_cnt, name, test_err);
		test_err = 0;
	endtask

	task automatic print_counts();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
	endtask

endmodule

// File: bench/tb_i2s_rx_dma.sv
`timescale 1ns/1ns
`include "i2s_rx_defs.svh"

module tb_i2s_rx_dma;

	import i2s_rx_pkg::*;

	logic                   wbs_clk_i;
	logic                   rst_i;
	logic                   wbs_cyc_i;
	logic                   wbs_stb_i;
	logic                   wbs_we_i;
	logic [`WB_ADR_W-1:0]   wbs_adr_i;
	logic [`WB_DAT_W-1:0]   wbs_dat_i;
	logic [`WB_DAT_W-1:0]   wbs_dat_o;
	logic                   wbs_ack_o;
	logic                   i2s_sclk_i;
	logic                   i2s_ws_i;
	logic                   i2s_din_i;
	logic                   dma_req_o;
	logic                   dma_active_i;
	logic                   rx_intr_o;
	logic                   dma_intr_o;
	logic                   dis_intr_o;

	// FIFO model holding left words in arrival order
	logic [`I2S_WORD_W-1:0] model_q [$];
	logic                   rx_en;
	// Right LSB still owed at the start of the next frame
	logic                   prev_lsb;

	initial begin
		wbs_clk_i = 1'b0;
		forever #2 wbs_clk_i = ~wbs_clk_i;
	end

	i2s_rx_dma_top i2s_rx_dma_top_inst (
		.wbs_clk_i    (wbs_clk_i),
		.rst_i        (rst_i),
		.wbs_cyc_i    (wbs_cyc_i),
		.wbs_stb_i    (wbs_stb_i),
		.wbs_we_i     (wbs_we_i),
		.wbs_adr_i    (wbs_adr_i),
		.wbs_dat_i    (wbs_dat_i),
		.wbs_dat_o    (wbs_dat_o),
		.wbs_ack_o    (wbs_ack_o),
		.i2s_sclk_i   (i2s_sclk_i),
		.i2s_ws_i     (i2s_ws_i),
		.i2s_din_i    (i2s_din_i),
		.dma_req_o    (dma_req_o),
		.dma_active_i (dma_active_i),
		.rx_intr_o    (rx_intr_o),
		.dma_intr_o   (dma_intr_o),
		.dis_intr_o   (dis_intr_o)
	);

	i2s_rx_checker i2s_rx_checker_inst (
		.wbs_clk_i  (wbs_clk_i),
		.rx_intr_i  (rx_intr_o),
		.dma_intr_i (dma_intr_o),
		.dis_intr_i (dis_intr_o),
		.dma_req_i  (dma_req_o)
	);

	// ------------------------------
	// Timing helpers
	// ------------------------------
	task automatic next_cycles(input int n);
		repeat (n) begin
			@(posedge wbs_clk_i);
			#1;
		end
	endtask

	// One bit slot of 4 cycles low then 4 high
	task automatic send_bit(input logic ws, input logic din);
		i2s_sclk_i = 1'b0;
		i2s_ws_i   = ws;
		i2s_din_i  = din;
		next_cycles(4);
		i2s_sclk_i = 1'b1;
		next_cycles(4);
	endtask

	// ------------------------------
	// I2S frames
	// ------------------------------
	task automatic send_frames(input int count);
		logic [`I2S_WORD_W-1:0] left;
		logic [`I2S_WORD_W-1:0] right;
		int                     i;
		next_cycles(1);
		repeat (count) begin
			left  = `I2S_WORD_W'($urandom);
			right = `I2S_WORD_W'($urandom);
			// WS drops one slot ahead of the left MSB
			send_bit(1'b0, prev_lsb);
			for (i = `I2S_WORD_W - 1; i > 0; i--)
				send_bit(1'b0, left[i]);
			// Left LSB rides on the first WS high slot
			send_bit(1'b1, left[0]);
			if (rx_en)
				model_q.push_back(left);
			for (i = `I2S_WORD_W - 1; i > 0; i--)
				send_bit(1'b1, right[i]);
			prev_lsb = right[0];
		end
	endtask

	// ------------------------------
	// Wishbone master
	// ------------------------------
	task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
		input logic [`WB_DAT_W-1:0] wdat, output logic [`WB_DAT_W-1:0] rdat);
		int n;
		next_cycles(1);
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = we;
		wbs_adr_i = adr;
		wbs_dat_i = wdat;
		n = 0;
		while (!wbs_ack_o && n < 16) begin
			next_cycles(1);
			n++;
		end
		// Read data valid in the ack cycle
		rdat = wbs_dat_o;
		if (!wbs_ack_o)
			i2s_rx_checker_inst.report_fail($sformatf("no wishbone ack at address %0d", adr));
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] dat);
		logic [`WB_DAT_W-1:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	task automatic read_check(input logic [`WB_ADR_W-1:0] adr,
		input logic [`WB_DAT_W-1:0] exp, input string name);
		logic [`WB_DAT_W-1:0] dat;
		wb_read(adr, dat);
		i2s_rx_checker_inst.check_val(name, exp, dat);
	endtask

	// Receiver enable mirrored for the model
	task automatic set_enable(input logic en);
		wb_write(REG_I2S_EN, 32'(en));
		rx_en = en;
	endtask

	// ------------------------------
	// Expected register images
	// ------------------------------
	function automatic logic [`WB_DAT_W-1:0] fifo_sts_exp(input int level);
		logic [`WB_DAT_W-1:0] r;
		r = '0;
		r[`FIFO_AW:0] = (`FIFO_AW+1)'(level);
		r[16] = level == 0;
		r[17] = level == (1 << `FIFO_AW);
		return r;
	endfunction

	function automatic logic [`WB_DAT_W-1:0] dma_sts_exp(input dma_state_e st,
		input logic busy, input int remain);
		logic [`WB_DAT_W-1:0] r;
		r = '0;
		r[1:0] = 2'(st);
		r[2] = busy;
		r[16 +: `FIFO_AW+1] = (`FIFO_AW+1)'(remain);
		return r;
	endfunction

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [`WB_DAT_W-1:0]   rdat;
		logic [`I2S_WORD_W-1:0] word;
		logic [`FIFO_AW:0]      cnt;
		int                     n_dma;
		void'($urandom(82));
		rst_i        = 1'b1;
		wbs_cyc_i    = 1'b0;
		wbs_stb_i    = 1'b0;
		wbs_we_i     = 1'b0;
		wbs_adr_i    = '0;
		wbs_dat_i    = '0;
		i2s_sclk_i   = 1'b0;
		i2s_ws_i     = 1'b0;
		i2s_din_i    = 1'b0;
		dma_active_i = 1'b0;
		rx_en        = 1'b0;
		prev_lsb     = 1'b0;
		repeat (5) @(posedge wbs_clk_i);
		#1;
		rst_i = 1'b0;

		// Register read-back
		set_enable(1'b1);
		read_check(REG_I2S_EN, 32'h1, "wbs_dat_o@I2S_EN");
		wb_write(REG_INTR_EN, 32'h5);
		read_check(REG_INTR_EN, 32'h5, "wbs_dat_o@INTR_EN");
		cnt = (`FIFO_AW+1)'($urandom);
		wb_write(REG_DMA_CNT, 32'(cnt));
		read_check(REG_DMA_CNT, 32'(cnt), "wbs_dat_o@DMA_CNT");
		read_check(`WB_ADR_W'(1), `DEF_REG_VALUE, "wbs_dat_o@addr1");
		wb_write(REG_INTR_EN, 32'h0);
		i2s_rx_checker_inst.end_test("register read-back");

		// Left words only and in order
		send_frames(20);
		read_check(REG_FIFO_STS, fifo_sts_exp(model_q.size()), "wbs_dat_o@FIFO_STS");
		while (model_q.size() > 0) begin
			word = model_q.pop_front();
			read_check(REG_FIFO_DATA, 32'(word), "wbs_dat_o@FIFO_DATA");
		end
		read_check(REG_FIFO_DATA, 32'h0, "wbs_dat_o@FIFO_DATA");
		read_check(REG_FIFO_STS, fifo_sts_exp(0), "wbs_dat_o@FIFO_STS");
		i2s_rx_checker_inst.end_test("left samples in order");

		// Data available interrupt then flush
		send_frames(3);
		wb_write(REG_INTR_EN, 32'h1);
		i2s_rx_checker_inst.wait_pin("rx_intr_o", 1'b1, 8);
		read_check(REG_FIFO_STS, fifo_sts_exp(model_q.size()), "wbs_dat_o@FIFO_STS");
		wb_write(REG_FIFO_RST, 32'h1);
		model_q.delete();
		read_check(REG_FIFO_STS, fifo_sts_exp(0), "wbs_dat_o@FIFO_STS");
		i2s_rx_checker_inst.wait_pin("rx_intr_o", 1'b0, 8);
		i2s_rx_checker_inst.end_test("data-available interrupt and flush");

		// DMA transfer of N words
		n_dma = $urandom_range(8, 1);
		wb_write(REG_INTR_EN, 32'h2);
		wb_write(REG_DMA_CNT, 32'(n_dma));
		wb_write(REG_DMA_EN, 32'h1);
		read_check(REG_DMA_STS, dma_sts_exp(DMA_WAIT, 1'b1, n_dma), "wbs_dat_o@DMA_STS");
		send_frames(n_dma);
		i2s_rx_checker_inst.wait_pin("dma_req_o", 1'b1, 32);
		dma_active_i = 1'b1;
		repeat (n_dma) begin
			word = model_q.pop_front();
			read_check(REG_FIFO_DATA, 32'(word), "wbs_dat_o@FIFO_DATA");
		end
		i2s_rx_checker_inst.wait_pin("dma_intr_o", 1'b1, 8);
		dma_active_i = 1'b0;
		wb_read(REG_INTR_STS, rdat);
		i2s_rx_checker_inst.check_val("wbs_dat_o@INTR_STS[1]", 32'h1, 32'(rdat[1]));
		i2s_rx_checker_inst.expect_pin("dma_req_o", 1'b0);
		read_check(REG_DMA_STS, dma_sts_exp(DMA_IDLE, 1'b0, 0), "wbs_dat_o@DMA_STS");
		wb_write(REG_INTR_STS, 32'h2);
		i2s_rx_checker_inst.end_test("DMA transfer");

		// Bit clock already idle here so start from a cleared status
		wb_write(REG_INTR_EN, 32'h4);
		wb_write(REG_INTR_STS, 32'h4);
		i2s_rx_checker_inst.wait_pin("dis_intr_o", 1'b0, 4);
		send_frames(1);
		// Still low well short of the stop threshold
		next_cycles(`CLK_STOP_CYCLES - 8);
		i2s_rx_checker_inst.expect_pin("dis_intr_o", 1'b0);
		i2s_rx_checker_inst.wait_pin("dis_intr_o", 1'b1, 24);
		// Clear while the clock runs again
		fork
			send_frames(2);
			begin
				next_cycles(24);
				wb_write(REG_INTR_STS, 32'h4);
				wb_read(REG_INTR_STS, rdat);
				i2s_rx_checker_inst.check_val("wbs_dat_o@INTR_STS[2]", 32'h0, 32'(rdat[2]));
				i2s_rx_checker_inst.wait_pin("dis_intr_o", 1'b0, 4);
			end
		join
		i2s_rx_checker_inst.end_test("clock-stop detection");

		i2s_rx_checker_inst.print_counts();
		if (i2s_rx_checker_inst.err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/i2s_rx_pkg.sv
src/i2s_deserializer.sv
src/sample_fifo.sv
src/dma_req_fsm.sv
src/wb_reg_block.sv
src/i2s_rx_dma_top.sv
bench/i2s_rx_checker.sv
bench/tb_i2s_rx_dma.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I2S receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_i2s_rx_dma \
	-f vlog.f -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
